// ==== Bender.yml ====
package:
  name: icache

sources:
  - files:
      - hw/icache_pkg.sv
      - hw/icache_tag_array.sv
      - hw/icache_data_array.sv
      - hw/icache_lru.sv
      - hw/icache_miss_ctrl.sv
      - hw/icache_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/icache_assertions.sv
      - verification/icache_tb.sv

// ==== all.f ====
+incdir+include
hw/icache_pkg.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_lru.sv
hw/icache_miss_ctrl.sv
hw/icache_top.sv
verification/icache_assertions.sv
verification/icache_tb.sv

// ==== hw/icache_data_array.sv ====
// Two interleaved data banks, one dword per row
// Fill rotation by way and read row addressing
`timescale 1ns/100ps

module icache_data_array
  import icache_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    rd_v_i,
  input  index_t                  rd_index_i,
  input  logic                    rd_dword_i,
  input  logic                    fill_we_i,
  input  index_t                  fill_index_i,
  input  way_t                    fill_way_i,
  input  block_t                  fill_data_i,
  output bank_t [icache_ways-1:0] bank_o
);

  // Dword d of way w lives in bank (d + w) mod 2 at row {index, d}
  //
  // A read of row {index, d} in both banks returns dword d of both ways,
  // and the hit way later picks the bank

  int     fill_shift;
  block_t fill_rot;

  // Rotate the block left by the way, bank b then gets dword (b - way)
  assign fill_shift = fill_way_i * bank_bits;
  assign fill_rot   = (fill_data_i << fill_shift) | (fill_data_i >> (block_bits - fill_shift));

  for (genvar b = 0; b < icache_ways; b++)
  begin : g_bank
    bank_t mem [bank_rows];
    bank_t rd_data_r;
    logic  fill_dword;
    bank_t fill_word;

    // Dword of the filled line that this bank stores
    assign fill_dword = way_t'(b) - fill_way_i;
    assign fill_word  = fill_rot[b*bank_bits +: bank_bits];

    always_ff @(posedge clk_i)
    begin
      if (fill_we_i)
      begin
        mem[{fill_index_i, fill_dword}] <= fill_word;
      end
    end

    // Output register holds until the next read
    always_ff @(posedge clk_i)
    begin
      if (rd_v_i)
      begin
        rd_data_r <= mem[{rd_index_i, rd_dword_i}];
      end
    end

    assign bank_o[b] = rd_data_r;
  end

endmodule

// ==== hw/icache_lru.sv ====
// LRU bit per set with update on consumed hits
// Victim choice from the valid vector and the LRU bit
`timescale 1ns/100ps

module icache_lru
  import icache_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      rd_v_i,
  input  index_t    rd_index_i,
  input  logic      upd_v_i,
  input  index_t    upd_index_i,
  input  way_t      upd_way_i,
  input  way_mask_t valid_i,
  output way_t      repl_way_o
);

  // Each entry names the next victim of its set
  way_t   lru_r [icache_sets];
  index_t rd_index_r;
  way_t   lru_way;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_index_r <= '0;
      for (int s = 0; s < icache_sets; s++)
      begin
        lru_r[s] <= '0;
      end
    end
    else
    begin
      if (rd_v_i)
      begin
        rd_index_r <= rd_index_i;
      end
      // Point away from the way just used
      if (upd_v_i)
      begin
        lru_r[upd_index_i] <= ~upd_way_i;
      end
    end
  end

  assign lru_way = lru_r[rd_index_r];

  // Lowest invalid way first, else the LRU choice
  always_comb
  begin
    repl_way_o = lru_way;
    for (int w = icache_ways - 1; w >= 0; w--)
    begin
      if (!valid_i[w])
      begin
        repl_way_o = way_t'(w);
      end
    end
  end

endmodule

// ==== hw/icache_miss_ctrl.sv ====
// Blocking miss FSM of the instruction cache
// Fill request strobe and recovery re-read trigger
`timescale 1ns/100ps

module icache_miss_ctrl
  import icache_pkg::*;
(
  input  logic clk_i,
  input  logic reset_i,
  input  logic tv_miss_i,
  input  logic cache_req_yumi_i,
  input  logic cache_req_complete_i,
  output logic cache_req_v_o,
  output logic ready_o,
  output logic recover_o
);

  miss_state_e state_r;
  miss_state_e state_n;

  assign ready_o   = (state_r == e_ready);
  assign recover_o = (state_r == e_recover);

  // Fresh miss in ready, then held until the engine takes it
  assign cache_req_v_o = (ready_o && tv_miss_i) || (state_r == e_req);

  always_comb
  begin
    state_n = state_r;
    case (state_r)
      e_ready:
      begin
        if (tv_miss_i)
        begin
          state_n = cache_req_yumi_i ? e_miss : e_req;
        end
      end
      e_req:
      begin
        if (cache_req_yumi_i)
        begin
          state_n = e_miss;
        end
      end
      e_miss:
      begin
        // Engine is done with all fills
        if (cache_req_complete_i)
        begin
          state_n = e_recover;
        end
      end
      e_recover:
      begin
        state_n = e_ready;
      end
      default:
      begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r <= e_ready;
    end
    else
    begin
      state_r <= state_n;
    end
  end

endmodule

// ==== hw/icache_pkg.sv ====
// Geometry constants of the two-way L1 instruction cache
// Vector types for addresses, tags, ways and data
// Miss controller state encoding
package icache_pkg;

  //////////////////////////////////////////////////
  // Geometry
  //////////////////////////////////////////////////

  localparam int icache_ways      = 2;
  localparam int icache_sets      = 256;
  localparam int block_bits       = 128;
  localparam int bank_bits        = 64;
  localparam int instr_bits       = 32;
  localparam int vaddr_bits       = 32;
  localparam int page_offset_bits = 12;
  localparam int ptag_bits        = 20;
  localparam int index_bits       = 8;
  localparam int way_bits         = 1;

  // Index and block offset fill the page offset, so the index is untranslated
  localparam int block_offset_bits = page_offset_bits - index_bits;

  // Dword and word select inside a line
  localparam int dword_sel_bit = 3;
  localparam int word_sel_bit  = 2;

  // Rows per data bank, one dword of one way each
  localparam int bank_rows = icache_sets * (block_bits / bank_bits);

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  typedef logic [vaddr_bits-1:0]  vaddr_t;
  typedef logic [ptag_bits-1:0]   ptag_t;
  typedef logic [index_bits-1:0]  index_t;
  typedef logic [way_bits-1:0]    way_t;

  // One bit per way, for hit and valid vectors
  typedef logic [icache_ways-1:0] way_mask_t;

  typedef logic [instr_bits-1:0]  instr_t;
  typedef logic [bank_bits-1:0]   bank_t;
  typedef logic [block_bits-1:0]  block_t;

  // Blocking miss sequence
  typedef enum logic [1:0] {
    e_ready,
    e_req,
    e_miss,
    e_recover
  } miss_state_e;

endpackage

// ==== hw/icache_tag_array.sv ====
// Tag memory per way with registered reads
// Valid bits per way, set by fills and cleared per set
// Tag compare against the translated tag
`timescale 1ns/100ps

module icache_tag_array
  import icache_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  logic      rd_v_i,
  input  index_t    rd_index_i,
  input  ptag_t     ptag_i,
  input  logic      fill_we_i,
  input  index_t    fill_index_i,
  input  way_t      fill_way_i,
  input  ptag_t     fill_tag_i,
  input  logic      inval_v_i,
  input  index_t    inval_index_i,
  output way_mask_t hit_o,
  output way_mask_t valid_o
);

  index_t rd_index_r;

  // Set of the last read, selects the live valid bits
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_index_r <= '0;
    end
    else if (rd_v_i)
    begin
      rd_index_r <= rd_index_i;
    end
  end

  for (genvar w = 0; w < icache_ways; w++)
  begin : g_way
    ptag_t                  tag_mem [icache_sets];
    ptag_t                  tag_rd_r;
    logic [icache_sets-1:0] valid_r;
    logic                   fill_this_way;

    assign fill_this_way = fill_we_i && (fill_way_i == way_t'(w));

    always_ff @(posedge clk_i)
    begin
      if (fill_this_way)
      begin
        tag_mem[fill_index_i] <= fill_tag_i;
      end
      if (rd_v_i)
      begin
        tag_rd_r <= tag_mem[rd_index_i];
      end
    end

    // Invalidation wins over a fill to the same set
    always_ff @(posedge clk_i)
    begin
      if (reset_i)
      begin
        valid_r <= '0;
      end
      else
      begin
        if (fill_this_way)
        begin
          valid_r[fill_index_i] <= 1'b1;
        end
        if (inval_v_i)
        begin
          valid_r[inval_index_i] <= 1'b0;
        end
      end
    end

    assign valid_o[w] = valid_r[rd_index_r];
    assign hit_o[w]   = valid_r[rd_index_r] && (tag_rd_r == ptag_i);
  end

endmodule

// ==== hw/icache_top.sv ====
// Two-way VIPT instruction cache top
// TL and TV pipeline registers, bank and word selection
// Tag, data, LRU and miss controller instances
`timescale 1ns/100ps

module icache_top
  import icache_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,
  input  logic   v_i,
  input  vaddr_t vaddr_i,
  output logic   yumi_o,
  input  ptag_t  ptag_i,
  input  logic   ptag_v_i,
  output instr_t data_o,
  output logic   data_v_o,
  output logic   miss_v_o,
  input  logic   yumi_i,
  output logic   cache_req_v_o,
  output vaddr_t cache_req_addr_o,
  output way_t   cache_req_way_o,
  input  logic   cache_req_yumi_i,
  input  logic   cache_req_complete_i,
  input  logic   fill_v_i,
  input  index_t fill_index_i,
  input  way_t   fill_way_i,
  input  ptag_t  fill_tag_i,
  input  block_t fill_data_i,
  output logic   fill_yumi_o,
  input  logic   inval_v_i,
  input  index_t inval_index_i
);

  logic                    ready;
  logic                    recover;
  logic                    reload_r;
  logic                    tv_miss;
  logic                    tl_v_r;
  vaddr_t                  tl_vaddr_r;
  logic                    tl_adv;
  logic                    tl_reread;
  logic                    tv_v_r;
  vaddr_t                  tv_paddr_r;
  way_mask_t               tv_hit_r;
  way_mask_t               tv_valid_r;
  bank_t [icache_ways-1:0] tv_bank_r;
  way_mask_t               tv_hit;
  way_mask_t               tv_valid;
  bank_t [icache_ways-1:0] tv_bank;
  logic                    tv_free;
  logic                    tv_consume;
  way_t                    tv_hit_way;
  way_t                    bank_sel;
  bank_t                   bank_word;
  logic                    arr_rd_v;
  index_t                  arr_rd_index;
  logic                    arr_rd_dword;
  ptag_t                   arr_ptag;
  way_mask_t               arr_hit;
  way_mask_t               arr_valid;
  bank_t [icache_ways-1:0] arr_bank;
  logic                    fill_we;

  //////////////////////////////////////////////////
  // Stage control
  //////////////////////////////////////////////////

  assign tv_consume = data_v_o && yumi_i;
  assign tv_free    = !tv_v_r || tv_consume;
  // Recovery overwrote the array outputs a held TL fetch relies on
  assign tl_reread  = reload_r && tl_v_r;
  assign tl_adv     = tl_v_r && ptag_v_i && tv_free && !tl_reread;
  assign yumi_o     = v_i && ready && (!tl_v_r || tl_adv);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      tl_v_r   <= 1'b0;
      tv_v_r   <= 1'b0;
      reload_r <= 1'b0;
    end
    else
    begin
      reload_r <= recover;
      if (yumi_o)
      begin
        tl_v_r <= 1'b1;
      end
      else if (tl_adv)
      begin
        tl_v_r <= 1'b0;
      end
      if (tl_adv)
      begin
        tv_v_r <= 1'b1;
      end
      else if (tv_consume)
      begin
        tv_v_r <= 1'b0;
      end
    end
  end

  // Payload, TV reloads from the arrays in the cycle after recover
  always_ff @(posedge clk_i)
  begin
    if (yumi_o)
    begin
      tl_vaddr_r <= vaddr_i;
    end
    if (tl_adv)
    begin
      tv_paddr_r <= {ptag_i, tl_vaddr_r[page_offset_bits-1:0]};
    end
    if (tl_adv || reload_r)
    begin
      tv_hit_r   <= arr_hit;
      tv_valid_r <= arr_valid;
      tv_bank_r  <= arr_bank;
    end
  end

  assign tv_hit   = reload_r ? arr_hit : tv_hit_r;
  assign tv_valid = reload_r ? arr_valid : tv_valid_r;
  assign tv_bank  = reload_r ? arr_bank : tv_bank_r;

  //////////////////////////////////////////////////
  // Result and miss request
  //////////////////////////////////////////////////

  always_comb
  begin
    tv_hit_way = '0;
    for (int w = icache_ways - 1; w >= 0; w--)
    begin
      if (tv_hit[w])
      begin
        tv_hit_way = way_t'(w);
      end
    end
  end

  // Bank (dword + way) mod 2, then the word inside the dword
  assign bank_sel  = tv_paddr_r[dword_sel_bit] + tv_hit_way;
  assign bank_word = tv_bank[bank_sel];
  assign data_o    = bank_word[tv_paddr_r[word_sel_bit]*instr_bits +: instr_bits];

  assign data_v_o = ready && tv_v_r && (|tv_hit);
  assign miss_v_o = tv_v_r && !data_v_o;
  assign tv_miss  = tv_v_r && !(|tv_hit);

  assign cache_req_addr_o = {tv_paddr_r[vaddr_bits-1:block_offset_bits],
                             {block_offset_bits{1'b0}}};

  //////////////////////////////////////////////////
  // Array access
  //////////////////////////////////////////////////

  assign arr_rd_v = yumi_o || recover || tl_reread;

  always_comb
  begin
    if (recover)
    begin
      arr_rd_index = tv_paddr_r[block_offset_bits +: index_bits];
      arr_rd_dword = tv_paddr_r[dword_sel_bit];
    end
    else if (tl_reread)
    begin
      arr_rd_index = tl_vaddr_r[block_offset_bits +: index_bits];
      arr_rd_dword = tl_vaddr_r[dword_sel_bit];
    end
    else
    begin
      arr_rd_index = vaddr_i[block_offset_bits +: index_bits];
      arr_rd_dword = vaddr_i[dword_sel_bit];
    end
  end

  // TV's own tag for the reload compare
  assign arr_ptag    = reload_r ? tv_paddr_r[vaddr_bits-1:page_offset_bits] : ptag_i;
  assign fill_yumi_o = !arr_rd_v;
  assign fill_we     = fill_v_i && fill_yumi_o;

  icache_tag_array tag_array_inst (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .rd_v_i        (arr_rd_v),
    .rd_index_i    (arr_rd_index),
    .ptag_i        (arr_ptag),
    .fill_we_i     (fill_we),
    .fill_index_i  (fill_index_i),
    .fill_way_i    (fill_way_i),
    .fill_tag_i    (fill_tag_i),
    .inval_v_i     (inval_v_i),
    .inval_index_i (inval_index_i),
    .hit_o         (arr_hit),
    .valid_o       (arr_valid)
  );

  icache_data_array data_array_inst (
    .clk_i        (clk_i),
    .rd_v_i       (arr_rd_v),
    .rd_index_i   (arr_rd_index),
    .rd_dword_i   (arr_rd_dword),
    .fill_we_i    (fill_we),
    .fill_index_i (fill_index_i),
    .fill_way_i   (fill_way_i),
    .fill_data_i  (fill_data_i),
    .bank_o       (arr_bank)
  );

  icache_lru lru_inst (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .rd_v_i      (tl_adv),
    .rd_index_i  (tl_vaddr_r[block_offset_bits +: index_bits]),
    .upd_v_i     (tv_consume),
    .upd_index_i (tv_paddr_r[block_offset_bits +: index_bits]),
    .upd_way_i   (tv_hit_way),
    .valid_i     (tv_valid),
    .repl_way_o  (cache_req_way_o)
  );

  icache_miss_ctrl miss_ctrl_inst (
    .clk_i                (clk_i),
    .reset_i              (reset_i),
    .tv_miss_i            (tv_miss),
    .cache_req_yumi_i     (cache_req_yumi_i),
    .cache_req_complete_i (cache_req_complete_i),
    .cache_req_v_o        (cache_req_v_o),
    .ready_o              (ready),
    .recover_o            (recover)
  );

endmodule

// ==== include/icache_tb_pattern.svh ====
// Memory content rule for the fetch checks
// Each word is derived from its own byte address

localparam logic [31:0] pattern_key = 32'h6b5d_29c3;

// Word stored at a word-aligned address
function automatic logic [31:0] pattern_word(input logic [31:0] addr);
  pattern_word = {addr[15:0], addr[31:16]} ^ pattern_key;
endfunction

// ==== verification/icache_assertions.sv ====
// Port-level model of accepted fetches, fills and LRU state
// Concurrent checks on data, hits, requests and victim choice
`timescale 1ns/100ps

module icache_assertions
  import icache_pkg::*;
(
  input logic   clk_i,
  input logic   reset_i,
  input logic   v_i,
  input logic   yumi_o,
  input vaddr_t vaddr_i,
  input instr_t data_o,
  input logic   data_v_o,
  input logic   miss_v_o,
  input logic   yumi_i,
  input logic   cache_req_v_o,
  input vaddr_t cache_req_addr_o,
  input way_t   cache_req_way_o,
  input logic   cache_req_yumi_i,
  input logic   fill_v_i,
  input index_t fill_index_i,
  input way_t   fill_way_i,
  input ptag_t  fill_tag_i,
  input logic   fill_yumi_o,
  input logic   inval_v_i,
  input index_t inval_index_i
);

  `include "icache_tb_pattern.svh"

  int        fail_count = 0;
  vaddr_t    addr_q [4];
  logic [1:0] rd_ptr;
  logic [1:0] wr_ptr;
  logic [2:0] count;
  way_mask_t mvalid [icache_sets];
  ptag_t     mtag [icache_sets][icache_ways];
  way_t      mlru [icache_sets];
  vaddr_t    front;
  index_t    front_set;
  instr_t    exp_word;
  vaddr_t    exp_line;
  way_t      exp_way;
  way_t      front_way;
  way_mask_t front_match;
  logic      front_present;
  logic      fetch_present;

  // Ways of the model that hold the line of an address
  function automatic way_mask_t line_match(input vaddr_t a);
    index_t s;
    s = a[block_offset_bits +: index_bits];
    for (int w = 0; w < icache_ways; w++)
    begin
      line_match[w] = mvalid[s][w] && (mtag[s][w] == a[vaddr_bits-1:page_offset_bits]);
    end
  endfunction

  always_comb
  begin
    front         = addr_q[rd_ptr];
    front_set     = front[block_offset_bits +: index_bits];
    front_match   = line_match(front);
    front_present = |front_match;
    fetch_present = |line_match(vaddr_i);
    exp_word      = pattern_word({front[31:2], 2'b00});
    exp_line      = {front[31:4], 4'b0000};
    front_way     = '0;
    // Lowest invalid way, else the LRU pick
    exp_way = mlru[front_set];
    for (int w = icache_ways - 1; w >= 0; w--)
    begin
      if (front_match[w])
      begin
        front_way = way_t'(w);
      end
      if (!mvalid[front_set][w])
      begin
        exp_way = way_t'(w);
      end
    end
  end

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
      for (int s = 0; s < icache_sets; s++)
      begin
        mvalid[s] <= '0;
        mlru[s]   <= '0;
      end
    end
    else
    begin
      if (fill_v_i && fill_yumi_o)
      begin
        mvalid[fill_index_i][fill_way_i] <= 1'b1;
        mtag[fill_index_i][fill_way_i]   <= fill_tag_i;
      end
      if (inval_v_i)
      begin
        mvalid[inval_index_i] <= '0;
      end
      if (v_i && yumi_o)
      begin
        addr_q[wr_ptr] <= vaddr_i;
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (data_v_o && yumi_i)
      begin
        rd_ptr <= rd_ptr + 1'b1;
        mlru[front_set] <= ~front_way;
      end
      count <= count + 3'(v_i && yumi_o) - 3'(data_v_o && yumi_i);
    end
  end

  //////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////

  a_data: assert property (@(posedge clk_i) disable iff (reset_i)
    (data_v_o && yumi_i) |-> data_o == exp_word)
    else
    begin
      $error("ERR %0t data_o exp=%h got=%h", $time, exp_word, data_o);
      fail_count++;
    end

  a_hit_known: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_o |-> front_present)
    else
    begin
      $error("ERR %0t data_v_o exp=0 got=1", $time);
      fail_count++;
    end

  a_req_miss: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |-> miss_v_o && !front_present)
    else
    begin
      $error("ERR %0t cache_req_v_o exp=0 got=1", $time);
      fail_count++;
    end

  a_req_addr: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |-> cache_req_addr_o == exp_line)
    else
    begin
      $error("ERR %0t cache_req_addr_o exp=%h got=%h", $time, exp_line, cache_req_addr_o);
      fail_count++;
    end

  a_req_way: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_v_o |-> cache_req_way_o == exp_way)
    else
    begin
      $error("ERR %0t cache_req_way_o exp=%0d got=%0d", $time, exp_way, cache_req_way_o);
      fail_count++;
    end

  // Request held with the same payload until taken
  a_req_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    (cache_req_v_o && !cache_req_yumi_i) |=>
      cache_req_v_o && $stable(cache_req_addr_o) && $stable(cache_req_way_o))
    else
    begin
      $error("ERR %0t cache_req_v_o exp=1 got=%b", $time, cache_req_v_o);
      fail_count++;
    end

  a_hit_time: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_i && yumi_o && count == 0 && fetch_present) |-> ##2 data_v_o)
    else
    begin
      $error("ERR %0t data_v_o exp=1 got=%b", $time, data_v_o);
      fail_count++;
    end

  a_reset: assert property (@(posedge clk_i)
    reset_i |=> !data_v_o && !miss_v_o && !cache_req_v_o)
    else
    begin
      $error("ERR %0t data_v_o|miss_v_o|cache_req_v_o exp=0 got=1", $time);
      fail_count++;
    end

  a_excl: assert property (@(posedge clk_i) disable iff (reset_i)
    !(data_v_o && cache_req_v_o))
    else
    begin
      $error("ERR %0t cache_req_v_o exp=0 got=1", $time);
      fail_count++;
    end

endmodule

bind icache_top icache_assertions assertions_inst (.*);

// ==== verification/icache_tb.sv ====
// Testbench for the instruction cache
// Clock, reset, random fetches, fill engine model, closing report
`timescale 1ns/100ps

module icache_tb;
  import icache_pkg::*;

  `include "icache_tb_pattern.svh"

  logic   clk_i;
  logic   reset_i;
  logic   v_i;
  vaddr_t vaddr_i;
  logic   yumi_o;
  ptag_t  ptag_i;
  logic   ptag_v_i;
  instr_t data_o;
  logic   data_v_o;
  logic   miss_v_o;
  logic   yumi_i;
  logic   cache_req_v_o;
  vaddr_t cache_req_addr_o;
  way_t   cache_req_way_o;
  logic   cache_req_yumi_i;
  logic   cache_req_complete_i;
  logic   fill_v_i;
  index_t fill_index_i;
  way_t   fill_way_i;
  ptag_t  fill_tag_i;
  block_t fill_data_i;
  logic   fill_yumi_o;
  logic   inval_v_i;
  index_t inval_index_i;

  logic [31:0] rand_state = 32'd36;
  int          timeouts = 0;
  int          outstanding = 0;
  vaddr_t      last_addr = '0;

  icache_top icache_top_inst (.*);

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  function automatic logic [31:0] xorshift_next();
    logic [31:0] x;
    x = rand_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rand_state = x;
    return x;
  endfunction

  // Few tags over few sets, so ways get evicted
  function automatic vaddr_t make_addr(input logic [7:0] r);
    return {18'h0, r[1:0], 6'h0, r[3:2], r[5:4], 2'b00};
  endfunction

  // One cycle of bookkeeping from the values seen before the edge
  task automatic track_cycle();
    logic took;
    logic cons;
    @(negedge clk_i);
    took = v_i && yumi_o;
    cons = data_v_o && yumi_i;
    @(posedge clk_i);
    #2;
    if (took)
    begin
      last_addr = vaddr_i;
      outstanding++;
    end
    if (cons)
    begin
      outstanding--;
    end
    ptag_i = last_addr[vaddr_bits-1:page_offset_bits];
  endtask

  //////////////////////////////////////////////////
  // Fill engine model
  //////////////////////////////////////////////////

  initial
  begin
    vaddr_t line;
    int     n;
    way_t   way;
    forever
    begin
      @(negedge clk_i);
      if (cache_req_v_o && !reset_i)
      begin
        line = cache_req_addr_o;
        way  = cache_req_way_o;
        repeat (line[4] + 1) @(posedge clk_i);
        #2 cache_req_yumi_i = 1'b1;
        @(posedge clk_i);
        #2 cache_req_yumi_i = 1'b0;
        repeat (2) @(posedge clk_i);
        #2;
        fill_v_i     = 1'b1;
        fill_way_i   = way;
        fill_index_i = line[block_offset_bits +: index_bits];
        fill_tag_i   = line[vaddr_bits-1:page_offset_bits];
        for (int i = 0; i < 4; i++)
        begin
          fill_data_i[i*instr_bits +: instr_bits] = pattern_word(line + 32'(4 * i));
        end
        n = 0;
        do
        begin
          @(negedge clk_i);
          n++;
        end
        while (!fill_yumi_o && n < 50);
        if (!fill_yumi_o)
        begin
          $display("timeout: fill never accepted by the cache");
          timeouts++;
        end
        @(posedge clk_i);
        #2 fill_v_i = 1'b0;
        cache_req_complete_i = 1'b1;
        @(posedge clk_i);
        #2 cache_req_complete_i = 1'b0;
      end
    end
  end

  //////////////////////////////////////////////////
  // Fetch stimulus
  //////////////////////////////////////////////////

  initial
  begin
    logic [31:0] r;
    int          n;
    reset_i = 1'b1;
    v_i = 1'b0;
    vaddr_i = '0;
    ptag_i = '0;
    ptag_v_i = 1'b1;
    yumi_i = 1'b0;
    cache_req_yumi_i = 1'b0;
    cache_req_complete_i = 1'b0;
    fill_v_i = 1'b0;
    fill_index_i = '0;
    fill_way_i = '0;
    fill_tag_i = '0;
    fill_data_i = '0;
    inval_v_i = 1'b0;
    inval_index_i = '0;
    repeat (3) @(posedge clk_i);
    #2 reset_i = 1'b0;

    for (int c = 0; c < 1500; c++)
    begin
      track_cycle();
      r = xorshift_next();
      inval_v_i = 1'b0;
      // Invalidate only with nothing in flight
      if (outstanding == 0 && r[4:0] == 5'd0)
      begin
        v_i           = 1'b0;
        inval_v_i     = 1'b1;
        inval_index_i = index_t'(r[6:5]);
      end
      else
      begin
        v_i     = (r[7:5] != 3'd0);
        vaddr_i = make_addr(r[15:8]);
      end
      yumi_i = (r[18:16] != 3'd0);
    end

    // Drain the pipeline
    v_i = 1'b0;
    inval_v_i = 1'b0;
    yumi_i = 1'b1;
    n = 0;
    while (outstanding != 0 && n < 300)
    begin
      track_cycle();
      n++;
    end
    if (outstanding != 0)
    begin
      $display("timeout: fetches still outstanding after the drain");
      timeouts++;
    end
    repeat (2) @(posedge clk_i);

    $display("timeouts=%0d assertion_failures=%0d", timeouts,
             icache_top_inst.assertions_inst.fail_count);
    if (timeouts == 0 && icache_top_inst.assertions_inst.fail_count == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
